/* rtl/ts_pkg.sv */
package ts_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Packet geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int pkt_bytes = 188;
	localparam int pkt_words = pkt_bytes / 4;
	localparam logic [7:0] sync_byte = 8'h47;
	localparam int pid_w = 13;

	// Register map, byte addresses
	localparam logic [11:0] adr_ctrl = 12'h000;
	localparam logic [11:0] adr_pid0 = 12'h004;
	localparam logic [11:0] adr_pid1 = 12'h008;
	localparam logic [11:0] adr_count = 12'h00C;
	localparam logic [11:0] adr_buf0 = 12'h400;
	localparam logic [11:0] adr_buf1 = 12'h800;

	typedef struct packed {
		logic [7:0] data;
		logic valid;
		logic [7:0] pos;
		logic last;
	} ts_beat_t;

	typedef struct packed {
		logic [pid_w-1:0] pid;
		logic pid_valid;
	} ts_hdr_t;

	// PID register as the channel decodes it
	typedef struct packed {
		logic [14:0] pad1;
		logic enable;
		logic [2:0] pad0;
		logic [pid_w-1:0] pid;
	} pid_fields_t;

	typedef union packed {
		logic [31:0] raw;
		pid_fields_t fields;
	} pid_reg_u;

	typedef struct packed {
		logic [15:0] pkt_count;
		logic [31:0] rd_data;
	} cap_status_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [11:0] adr;
		logic [31:0] dat_w;
		logic [3:0] sel;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [31:0] dat_r;
	} wb_rsp_t;

endpackage

/* rtl/ts_header_parser.sv */
`timescale 1ns/1ps

module ts_header_parser (
	input logic clk,
	input logic rst_n,
	input logic [7:0] ts_data,
	input logic ts_valid,
	input logic ts_sync,
	output ts_pkg::ts_beat_t beat,
	output ts_pkg::ts_hdr_t hdr
);
	import ts_pkg::*;

	localparam logic [7:0] last_pos = 8'(pkt_bytes - 1);

	logic in_pkt;
	logic [7:0] pos_cnt;
	logic [7:0] byte1;
	logic start;
	logic take;

	// A sync flag alone is not enough, the byte must be the marker too
	assign start = ts_valid && ts_sync && (ts_data == sync_byte);
	assign take = ts_valid && in_pkt && !start;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Alignment FSM, pos_cnt is the position of the next byte
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			in_pkt <= 1'b0;
			pos_cnt <= '0;
		end else if (start) begin
			in_pkt <= 1'b1;
			pos_cnt <= 8'd1;
		end else if (take) begin
			if (pos_cnt == last_pos) begin
				in_pkt <= 1'b0;
				pos_cnt <= '0;
			end else begin
				pos_cnt <= pos_cnt + 8'd1;
			end
		end
	end

	// Registered beat and header outputs
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			beat <= '0;
			hdr <= '0;
		end else begin
			beat.valid <= start || take;
			beat.data <= ts_data;
			beat.pos <= start ? 8'd0 : pos_cnt;
			beat.last <= take && (pos_cnt == last_pos);
			hdr.pid_valid <= take && (pos_cnt == 8'd2);
			if (take && pos_cnt == 8'd2)
				hdr.pid <= {byte1[4:0], ts_data};
		end
	end

	// Byte 1 carries the upper PID bits
	always_ff @(posedge clk) begin
		if (take && pos_cnt == 8'd1)
			byte1 <= ts_data;
	end

endmodule

/* rtl/pid_capture.sv */
`timescale 1ns/1ps

module pid_capture (
	input logic clk,
	input logic rst_n,
	input ts_pkg::ts_beat_t beat,
	input ts_pkg::ts_hdr_t hdr,
	input ts_pkg::pid_reg_u pid_cfg,
	input logic match_en,
	input logic [5:0] buf_adr,
	output ts_pkg::cap_status_t status
);
	import ts_pkg::*;

	// Two packet banks, rd_sel picks the one the host sees
	logic [31:0] bank [2][pkt_words];
	logic rd_sel;
	logic keep;
	logic [15:0] pkt_count;
	logic [31:0] rd_q;
	logic [5:0] wr_word;
	logic [1:0] wr_lane;
	logic hit;
	logic pkt_done;

	assign wr_word = beat.pos[7:2];
	assign wr_lane = beat.pos[1:0];

	// All three enables must agree before a packet is kept
	assign hit = match_en && pid_cfg.fields.enable && (hdr.pid == pid_cfg.fields.pid);
	assign pkt_done = beat.valid && beat.last && keep;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Fill side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Every beat lands in the fill bank, little-endian lanes
	always_ff @(posedge clk) begin
		if (beat.valid)
			bank[!rd_sel][wr_word][8*wr_lane +: 8] <= beat.data;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			keep <= 1'b0;
			rd_sel <= 1'b0;
			pkt_count <= '0;
		end else begin
			if (beat.valid && beat.pos == 8'd0) begin
				// A fresh start drops any decision from a cut packet
				keep <= 1'b0;
			end else if (hdr.pid_valid) begin
				keep <= hit;
			end else if (pkt_done) begin
				keep <= 1'b0;
				rd_sel <= !rd_sel;
				pkt_count <= pkt_count + 16'd1;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// One cycle read latency, words past the packet read as zero
	always_ff @(posedge clk) begin
		if (buf_adr < 6'(pkt_words))
			rd_q <= bank[rd_sel][buf_adr];
		else
			rd_q <= '0;
	end

	assign status = '{pkt_count: pkt_count, rd_data: rd_q};

endmodule

/* rtl/wb_regs.sv */
`timescale 1ns/1ps

module wb_regs (
	input logic clk,
	input logic rst_n,
	input ts_pkg::wb_req_t wb_req,
	output ts_pkg::wb_rsp_t wb_rsp,
	output logic match_en,
	output ts_pkg::pid_reg_u pid_cfg0,
	output ts_pkg::pid_reg_u pid_cfg1,
	output logic [5:0] buf_adr,
	input ts_pkg::cap_status_t status0,
	input ts_pkg::cap_status_t status1
);
	import ts_pkg::*;

	logic req;
	logic start;
	logic stage1;
	logic ack_q;
	logic [31:0] rd_mux;
	logic [31:0] dat_q;

	function automatic logic [31:0] lane_merge(
		input logic [31:0] old_w,
		input logic [31:0] new_w,
		input logic [3:0] sel
	);
		logic [31:0] res;
		res = old_w;
		for (int i = 0; i < 4; i++) begin
			if (sel[i])
				res[8*i +: 8] = new_w[8*i +: 8];
		end
		return res;
	endfunction

	assign req = wb_req.cyc && wb_req.stb;
	// No new access while one is still in the pipeline
	assign start = req && !stage1 && !ack_q;
	assign buf_adr = wb_req.adr[7:2];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Two-stage ack pipeline
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stage1 <= 1'b0;
			ack_q <= 1'b0;
		end else begin
			stage1 <= start;
			ack_q <= stage1 && req;
		end
	end

	// Count and buffer addresses fall to the default branch on writes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			match_en <= 1'b0;
			pid_cfg0 <= '0;
			pid_cfg1 <= '0;
		end else if (start && wb_req.we) begin
			case (wb_req.adr[11:2])
				adr_ctrl[11:2]: begin
					if (wb_req.sel[0])
						match_en <= wb_req.dat_w[0];
				end
				adr_pid0[11:2]: pid_cfg0.raw <= lane_merge(pid_cfg0.raw, wb_req.dat_w, wb_req.sel);
				adr_pid1[11:2]: pid_cfg1.raw <= lane_merge(pid_cfg1.raw, wb_req.dat_w, wb_req.sel);
				default: ;
			endcase
		end
	end

	// Channel buffer words arrive registered one cycle into the access
	always_comb begin
		rd_mux = '0;
		case (wb_req.adr[11:8])
			adr_buf0[11:8]: rd_mux = status0.rd_data;
			adr_buf1[11:8]: rd_mux = status1.rd_data;
			4'h0: begin
				case (wb_req.adr[7:2])
					adr_ctrl[7:2]: rd_mux = {31'b0, match_en};
					adr_pid0[7:2]: rd_mux = pid_cfg0.raw;
					adr_pid1[7:2]: rd_mux = pid_cfg1.raw;
					adr_count[7:2]: rd_mux = {status1.pkt_count, status0.pkt_count};
					default: rd_mux = '0;
				endcase
			end
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (stage1)
			dat_q <= rd_mux;
	end

	assign wb_rsp = '{ack: ack_q, dat_r: dat_q};

endmodule

/* rtl/ts_monitor_top.sv */
`timescale 1ns/1ps

module ts_monitor_top (
	input logic clk,
	input logic rst_n,
	input logic [7:0] ts_data,
	input logic ts_valid,
	input logic ts_sync,
	input ts_pkg::wb_req_t wb_req,
	output ts_pkg::wb_rsp_t wb_rsp
);
	import ts_pkg::*;

	ts_beat_t beat;
	ts_hdr_t hdr;
	pid_reg_u pid_cfg0;
	pid_reg_u pid_cfg1;
	logic match_en;
	logic [5:0] buf_adr;
	cap_status_t status0;
	cap_status_t status1;

	ts_header_parser parser_i (
		.clk(clk),
		.rst_n(rst_n),
		.ts_data(ts_data),
		.ts_valid(ts_valid),
		.ts_sync(ts_sync),
		.beat(beat),
		.hdr(hdr)
	);

	// Both channels see the same aligned stream
	pid_capture cap0_i (
		.clk(clk),
		.rst_n(rst_n),
		.beat(beat),
		.hdr(hdr),
		.pid_cfg(pid_cfg0),
		.match_en(match_en),
		.buf_adr(buf_adr),
		.status(status0)
	);

	pid_capture cap1_i (
		.clk(clk),
		.rst_n(rst_n),
		.beat(beat),
		.hdr(hdr),
		.pid_cfg(pid_cfg1),
		.match_en(match_en),
		.buf_adr(buf_adr),
		.status(status1)
	);

	wb_regs regs_i (
		.clk(clk),
		.rst_n(rst_n),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.match_en(match_en),
		.pid_cfg0(pid_cfg0),
		.pid_cfg1(pid_cfg1),
		.buf_adr(buf_adr),
		.status0(status0),
		.status1(status1)
	);

endmodule

/* sim/ts_stim.svh */
`ifndef TS_STIM_SVH
`define TS_STIM_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Compare tasks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
task automatic check_word(input string name, input ts_pkg::pid_reg_u got,
	input ts_pkg::pid_reg_u exp);
	if (got.raw !== exp.raw) begin
		$display("FAILED %s: got 0x%h expected 0x%h", name, got.raw, exp.raw);
		value_errors++;
	end
endtask

task automatic check_count(input string name, input logic [15:0] got, input logic [15:0] exp);
	if (got !== exp) begin
		$display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
		value_errors++;
	end
endtask

task automatic check_ack(input int cycles);
	if (cycles != 2) begin
		$display("FAILED wb_ack_delay: got 0x%h expected 0x%h", cycles, 2);
		value_errors++;
	end
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic access
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
task automatic bus_access(input logic we, input logic [11:0] adr, input logic [31:0] wdat,
	input logic [3:0] sel, output logic [31:0] rdat);
	int cycles;
	cycles = 0;
	rdat = '0;
	wb_req.cyc = 1'b1;
	wb_req.stb = 1'b1;
	wb_req.we = we;
	wb_req.adr = adr;
	wb_req.dat_w = wdat;
	wb_req.sel = sel;
	do begin
		@(posedge clk);
		#1;
		cycles++;
	end while (!wb_rsp.ack && cycles < 8);
	if (wb_rsp.ack) begin
		rdat = wb_rsp.dat_r;
		check_ack(cycles);
	end else begin
		$display("No ack from the slave within 8 cycles at address 0x%h", adr);
		other_errors++;
	end
	wb_req.cyc = 1'b0;
	wb_req.stb = 1'b0;
	wb_req.we = 1'b0;
	@(posedge clk);
	#1;
	if (wb_rsp.ack) begin
		$display("Ack stayed high after the request at address 0x%h was dropped", adr);
		other_errors++;
	end
endtask

task automatic reg_write(input logic [11:0] adr, input logic [31:0] wdat, input logic [3:0] sel);
	logic [31:0] ignored;
	bus_access(1'b1, adr, wdat, sel, ignored);
endtask

task automatic reg_read(input logic [11:0] adr, output logic [31:0] rdat);
	bus_access(1'b0, adr, 32'h0, 4'hf, rdat);
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream side
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
task automatic drive_byte(input logic [7:0] data, input logic sync);
	ts_valid = 1'b1;
	ts_sync = sync;
	ts_data = data;
	@(posedge clk);
	#1;
endtask

// Decoy idles carry a marker byte with the sync flag but no valid
task automatic idle_cycles(input int n, input logic decoy);
	ts_valid = 1'b0;
	ts_sync = decoy;
	ts_data = decoy ? sync_byte : 8'h00;
	repeat (n) begin
		@(posedge clk);
		#1;
	end
	ts_sync = 1'b0;
endtask

// Sends the first n bytes of a packet, a whole one updates the expected state
task automatic send_packet(input logic [12:0] pid, input int n, input logic gaps);
	logic [7:0] pkt [pkt_bytes];
	for (int i = 0; i < pkt_bytes; i++)
		pkt[i] = 8'($urandom);
	pkt[0] = sync_byte;
	pkt[1] = {pkt[1][7:5], pid[12:8]};
	pkt[2] = pid[7:0];
	for (int i = 0; i < n; i++) begin
		if (gaps && (i % 7 == 3))
			idle_cycles(1 + i % 3, 1'b1);
		drive_byte(pkt[i], i == 0);
	end
	ts_valid = 1'b0;
	if (n == pkt_bytes) begin
		for (int c = 0; c < 2; c++) begin
			if (match_model && cfg_model[c].fields.enable && cfg_model[c].fields.pid == pid) begin
				exp_count[c]++;
				for (int w = 0; w < pkt_words; w++)
					exp_buf[c][w] = {pkt[4*w+3], pkt[4*w+2], pkt[4*w+1], pkt[4*w]};
			end
		end
	end
endtask

`endif

/* sim/tb_ts_monitor.sv */
`timescale 1ns/1ps

module tb_ts_monitor;
	import ts_pkg::*;

	// Room for 40 packets of stream plus the register traffic
	localparam int watchdog_cycles = 40 * pkt_bytes + 2000;

	logic clk;
	logic rst_n;
	logic [7:0] ts_data;
	logic ts_valid;
	logic ts_sync;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;

	int value_errors;
	int other_errors;
	pid_reg_u cfg_model [2];
	logic match_model;
	logic [15:0] exp_count [2];
	logic [31:0] exp_buf [2][pkt_words];

	`include "ts_stim.svh"

	ts_monitor_top dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.ts_data(ts_data),
		.ts_valid(ts_valid),
		.ts_sync(ts_sync),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	task automatic config_pid(input int ch, input logic [12:0] pid, input logic en);
		pid_reg_u w;
		w.raw = '0;
		w.fields.pid = pid;
		w.fields.enable = en;
		cfg_model[ch] = w;
		reg_write(ch == 0 ? adr_pid0 : adr_pid1, w.raw, 4'hf);
	endtask

	task automatic config_enable(input logic en);
		match_model = en;
		reg_write(adr_ctrl, {31'b0, en}, 4'hf);
	endtask

	// Buffer words are read only for channels that captured a packet
	task automatic verify_channels();
		logic [31:0] rd;
		reg_read(adr_count, rd);
		check_count("ch0 pkt_count", rd[15:0], exp_count[0]);
		check_count("ch1 pkt_count", rd[31:16], exp_count[1]);
		for (int c = 0; c < 2; c++) begin
			if (exp_count[c] != 0) begin
				for (int w = 0; w < pkt_words; w++) begin
					reg_read((c == 0 ? adr_buf0 : adr_buf1) + 12'(4 * w), rd);
					check_word($sformatf("ch%0d buffer word %0d", c, w), rd, exp_buf[c][w]);
				end
			end
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic test_reset_regs();
		logic [31:0] rd;
		reg_read(adr_ctrl, rd);
		check_word("ctrl", rd, 32'h0);
		reg_read(adr_pid0, rd);
		check_word("pid0", rd, 32'h0);
		reg_read(adr_pid1, rd);
		check_word("pid1", rd, 32'h0);
		reg_read(adr_count, rd);
		check_word("count", rd, 32'h0);
		reg_read(12'h010, rd);
		check_word("unmapped 0x010", rd, 32'h0);
		reg_read(12'hc00, rd);
		check_word("unmapped 0xc00", rd, 32'h0);
		// Full word first, then one lane on top of it
		reg_write(adr_pid0, 32'hdead_beef, 4'hf);
		reg_write(adr_pid0, 32'haaaa_55aa, 4'h2);
		reg_read(adr_pid0, rd);
		check_word("pid0", rd, 32'hdead_55ef);
		reg_write(adr_pid1, 32'h1234_5678, 4'h5);
		reg_read(adr_pid1, rd);
		check_word("pid1", rd, 32'h0034_0078);
		reg_write(adr_ctrl, 32'hffff_ffff, 4'hf);
		reg_read(adr_ctrl, rd);
		check_word("ctrl", rd, 32'h1);
		reg_write(adr_count, 32'h1111_2222, 4'hf);
		reg_read(adr_count, rd);
		check_word("count", rd, 32'h0);
		config_enable(1'b0);
		config_pid(0, 13'h0, 1'b0);
		config_pid(1, 13'h0, 1'b0);
	endtask

	task automatic test_single();
		config_pid(0, 13'h0100, 1'b1);
		config_enable(1'b1);
		send_packet(13'h0100, pkt_bytes, 1'b0);
		idle_cycles(4, 1'b0);
		verify_channels();
	endtask

	task automatic test_both();
		logic [12:0] seq [8];
		seq = '{13'h1abc, 13'h0100, 13'h0abc, 13'h1abc, 13'h0055, 13'h1abc, 13'h0100, 13'h1fff};
		config_pid(1, 13'h1abc, 1'b1);
		foreach (seq[i])
			send_packet(seq[i], pkt_bytes, 1'b0);
		idle_cycles(4, 1'b0);
		verify_channels();
	endtask

	task automatic test_filter();
		config_pid(0, 13'h0100, 1'b0);
		send_packet(13'h0100, pkt_bytes, 1'b0);
		config_pid(0, 13'h0100, 1'b1);
		config_enable(1'b0);
		send_packet(13'h0100, pkt_bytes, 1'b0);
		send_packet(13'h1abc, pkt_bytes, 1'b0);
		config_enable(1'b1);
		send_packet(13'h0101, pkt_bytes, 1'b0);
		send_packet(13'h1abd, pkt_bytes, 1'b0);
		idle_cycles(4, 1'b0);
		verify_channels();
	endtask

	task automatic test_alignment();
		for (int i = 0; i < 30; i++)
			drive_byte(8'($urandom), 1'b0);
		// Flagged non-marker byte ahead of a body with PID 0x100
		drive_byte(8'h46, 1'b1);
		drive_byte(8'h01, 1'b0);
		drive_byte(8'h00, 1'b0);
		for (int i = 3; i < pkt_bytes; i++)
			drive_byte(8'($urandom), 1'b0);
		send_packet(13'h0100, 100, 1'b0);
		send_packet(13'h0100, pkt_bytes, 1'b1);
		send_packet(13'h1abc, pkt_bytes, 1'b1);
		idle_cycles(4, 1'b0);
		verify_channels();
	endtask

	initial begin
		void'($urandom(32'hc661b7c5));
		rst_n = 1'b0;
		ts_data = 8'h00;
		ts_valid = 1'b0;
		ts_sync = 1'b0;
		wb_req = '0;
		value_errors = 0;
		other_errors = 0;
		match_model = 1'b0;
		cfg_model[0] = '0;
		cfg_model[1] = '0;
		exp_count[0] = '0;
		exp_count[1] = '0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(posedge clk);
		#1;
		if (wb_rsp.ack) begin
			$display("Ack is high after reset with no request");
			other_errors++;
		end
		test_reset_regs();
		test_single();
		test_both();
		test_filter();
		test_alignment();
		$display("Errors: %0d value mismatches, %0d protocol faults", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
		$display("** FAIL **");
		$finish;
	end

endmodule

/* sources.f */
+incdir+sim
rtl/ts_pkg.sv
rtl/ts_header_parser.sv
rtl/pid_capture.sv
rtl/wb_regs.sv
rtl/ts_monitor_top.sv
sim/tb_ts_monitor.sv

/* Makefile */
TOP = tb_ts_monitor

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module ts_monitor_top
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing -f sources.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf obj_dir
